/* alu_execute.sv */
`timescale 1ns/1ps

module alu_execute import core_types_pkg::*, stage_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    ra_valid,
   output logic    ra_ready,
   input  exe_in_t ra_out,
   output logic    ex_valid,
   input  logic    ex_ready,
   output wb_in_t  ex_out
);

   wb_in_t ex_next;
   logic   take;

   assign ra_ready = ~ex_valid | ex_ready;
   assign take     = ra_valid & ra_ready;

   always_comb begin
      ex_next.is_store   = 1'b0;
      ex_next.dest       = ra_out.dest;
      ex_next.store_addr = ra_out.imm;
      case (ra_out.alu_op)
         OP_ADD:     ex_next.result = ra_out.operand_a + ra_out.operand_b;
         OP_SUB:     ex_next.result = ra_out.operand_a - ra_out.operand_b;
         OP_AND:     ex_next.result = ra_out.operand_a & ra_out.operand_b;
         OP_OR:      ex_next.result = ra_out.operand_a | ra_out.operand_b;
         OP_XOR:     ex_next.result = ra_out.operand_a ^ ra_out.operand_b;
         OP_MOV_IMM: ex_next.result = ra_out.imm;
         OP_STORE: begin
            ex_next.is_store = 1'b1;
            ex_next.result   = ra_out.operand_a;   // Store data from src_a
         end
         default:    ex_next.result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         ex_valid <= 1'b0;
      else if (take)
         ex_valid <= 1'b1;
      else if (ex_ready)
         ex_valid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (take)
         ex_out <= ex_next;
   end

endmodule

/* core_pipeline_top.sv */
`timescale 1ns/1ps

module core_pipeline_top import stage_pkg::*; #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    uop_valid,
   output logic    uop_ready,
   input  uop_t    uop,
   output logic    wmem_valid,
   input  logic    wmem_ready,
   output mem_wr_t wmem_req
);

   logic    q_valid;
   logic    q_ready;
   uop_t    q_uop;
   logic    ra_valid;
   logic    ra_ready;
   exe_in_t ra_out;
   logic    ex_valid;
   logic    ex_ready;
   wb_in_t  ex_out;
   reg_wr_t reg_wr;   // Retire path back into the register file

   uop_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) i_uop_queue (
      .clk       (clk),
      .arst_n    (arst_n),
      .uop_valid (uop_valid),
      .uop_ready (uop_ready),
      .uop       (uop),
      .q_valid   (q_valid),
      .q_ready   (q_ready),
      .q_uop     (q_uop)
   );

   reg_access i_reg_access (
      .clk      (clk),
      .arst_n   (arst_n),
      .q_valid  (q_valid),
      .q_ready  (q_ready),
      .q_uop    (q_uop),
      .ra_valid (ra_valid),
      .ra_ready (ra_ready),
      .ra_out   (ra_out),
      .reg_wr   (reg_wr)
   );

   alu_execute i_alu_execute (
      .clk      (clk),
      .arst_n   (arst_n),
      .ra_valid (ra_valid),
      .ra_ready (ra_ready),
      .ra_out   (ra_out),
      .ex_valid (ex_valid),
      .ex_ready (ex_ready),
      .ex_out   (ex_out)
   );

   writeback i_writeback (
      .clk        (clk),
      .arst_n     (arst_n),
      .ex_valid   (ex_valid),
      .ex_ready   (ex_ready),
      .ex_out     (ex_out),
      .reg_wr     (reg_wr),
      .wmem_valid (wmem_valid),
      .wmem_ready (wmem_ready),
      .wmem_req   (wmem_req)
   );

endmodule

/* core_types_pkg.sv */
package core_types_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [2:0]  reg_idx_t;

   // One register per index value
   localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

   typedef enum logic [2:0] {
      OP_ADD     = 3'd0,
      OP_SUB     = 3'd1,
      OP_AND     = 3'd2,
      OP_OR      = 3'd3,
      OP_XOR     = 3'd4,
      OP_MOV_IMM = 3'd5,
      OP_STORE   = 3'd6   // mem[imm] = src_a
   } alu_op_e;

endpackage

/* list.f */
core_types_pkg.sv
stage_pkg.sv
uop_queue.sv
reg_access.sv
alu_execute.sv
writeback.sv
core_pipeline_top.sv
tb_clock_gen.sv
tb_core_pipeline.sv

/* reg_access.sv */
`timescale 1ns/1ps

module reg_access import core_types_pkg::*, stage_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    q_valid,
   output logic    q_ready,
   input  uop_t    q_uop,
   output logic    ra_valid,
   input  logic    ra_ready,
   output exe_in_t ra_out,
   input  reg_wr_t reg_wr
);

   word_t               regs [NUM_REGS];
   logic [NUM_REGS-1:0] pending;
   logic [NUM_REGS-1:0] wr_clear;
   logic [NUM_REGS-1:0] pending_eff;
   logic                hazard;
   logic                issue;
   logic                sets_dest;
   word_t               rd_a;
   word_t               rd_b;

   // Mark released by a writeback in this same cycle
   assign wr_clear    = reg_wr.en ? (NUM_REGS'(1) << reg_wr.idx) : '0;
   assign pending_eff = pending & ~wr_clear;

   assign hazard = pending_eff[q_uop.src_a]
                 | (~q_uop.use_imm & pending_eff[q_uop.src_b])
                 | pending_eff[q_uop.dest];   // WAW

   assign q_ready   = (~ra_valid | ra_ready) & ~hazard;
   assign issue     = q_valid & q_ready;
   assign sets_dest = issue & (q_uop.alu_op != OP_STORE);

   // Write-first bypass
   always_comb begin
      rd_a = regs[q_uop.src_a];
      rd_b = regs[q_uop.src_b];
      if (reg_wr.en && reg_wr.idx == q_uop.src_a)
         rd_a = reg_wr.data;
      if (reg_wr.en && reg_wr.idx == q_uop.src_b)
         rd_b = reg_wr.data;
   end

   // Registers are architecturally zero after reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end else if (reg_wr.en) begin
         regs[reg_wr.idx] <= reg_wr.data;
      end
   end

   // Scoreboard
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= '0;
      end else begin
         pending <= pending_eff;
         if (sets_dest)
            pending[q_uop.dest] <= 1'b1;   // New owner wins over the clear
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         ra_valid <= 1'b0;
      else if (issue)
         ra_valid <= 1'b1;
      else if (ra_ready)
         ra_valid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         ra_out.alu_op    <= q_uop.alu_op;
         ra_out.dest      <= q_uop.dest;
         ra_out.operand_a <= rd_a;
         ra_out.operand_b <= q_uop.use_imm ? q_uop.imm : rd_b;
         ra_out.imm       <= q_uop.imm;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the core pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --timescale 1ns/1ps \
      --top-module tb_core_pipeline -f list.f; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/Vtb_core_pipeline > sim.log 2>&1; then
   cat sim.log
   echo "Simulation exited with an error"
   exit 1
fi

cat sim.log
if grep -qx "TESTBENCH PASSED" sim.log; then
   exit 0
fi
exit 1

/* stage_pkg.sv */
package stage_pkg;
   import core_types_pkg::*;

   typedef struct packed {
      alu_op_e  alu_op;
      reg_idx_t dest;
      reg_idx_t src_a;
      reg_idx_t src_b;
      logic     use_imm;
      word_t    imm;
   } uop_t;

   typedef struct packed {
      alu_op_e  alu_op;
      reg_idx_t dest;
      word_t    operand_a;
      word_t    operand_b;   // Register or immediate, already picked
      word_t    imm;
   } exe_in_t;

   typedef struct packed {
      logic     is_store;
      reg_idx_t dest;
      word_t    result;      // Store data when is_store
      addr_t    store_addr;
   } wb_in_t;

   typedef struct packed {
      logic     en;
      reg_idx_t idx;
      word_t    data;
   } reg_wr_t;

   typedef struct packed {
      addr_t address;
      word_t data;
   } mem_wr_t;

endpackage

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD_NS = 10,
   parameter int RESET_CYCLES   = 10
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk) arst_n = 1'b1;   // Release away from the sampling edge
   end

endmodule

/* tb_core_pipeline.sv */
`timescale 1ns/1ps

module tb_core_pipeline import core_types_pkg::*, stage_pkg::*; ();

   localparam int SEND_TIMEOUT  = 100;
   localparam int DRAIN_TIMEOUT = 500;
   localparam int RESET_TIMEOUT = 50;
   localparam int HOLD_CYCLES   = 40;
   localparam int SETTLE_CYCLES = 20;

   typedef struct packed {
      logic is_store;
      uop_t op;
   } step_t;

   logic        clk;
   logic        arst_n;
   logic        uop_valid;
   logic        uop_ready;
   uop_t        uop;
   logic        wmem_valid;
   logic        wmem_ready = 1'b0;
   mem_wr_t     wmem_req;
   step_t       prog [$];
   mem_wr_t     exp_q [$];
   word_t       model_regs [NUM_REGS];
   logic [31:0] rng = 32'd8892;
   logic        hold_req = 1'b0;
   int          hold_cycles = 0;
   int          hold_step;
   int          stores_seen = 0;
   int          store_errors = 0;
   int          errors = 0;
   int          timeouts = 0;
   logic        waiting = 1'b0;
   logic        saw_full = 1'b0;
   mem_wr_t     held_req;

   tb_clock_gen i_clock_gen (.clk(clk), .arst_n(arst_n));

   core_pipeline_top #(.QUEUE_DEPTH(4)) i_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .uop_valid  (uop_valid),
      .uop_ready  (uop_ready),
      .uop        (uop),
      .wmem_valid (wmem_valid),
      .wmem_ready (wmem_ready),
      .wmem_req   (wmem_req)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic void add_alu_step(input alu_op_e op, input int dest, input int a,
                                        input int b, input logic use_imm, input word_t imm);
      step_t s;
      s.is_store   = 1'b0;
      s.op.alu_op  = op;
      s.op.dest    = reg_idx_t'(dest);
      s.op.src_a   = reg_idx_t'(a);
      s.op.src_b   = reg_idx_t'(b);
      s.op.use_imm = use_imm;
      s.op.imm     = imm;
      prog.push_back(s);
   endfunction

   function automatic void add_store_step(input int src, input word_t addr);
      step_t s;
      s.is_store   = 1'b1;
      s.op.alu_op  = OP_STORE;
      s.op.dest    = reg_idx_t'(src);   // Same as src, keeps the WAW check quiet
      s.op.src_a   = reg_idx_t'(src);
      s.op.src_b   = reg_idx_t'(src);
      s.op.use_imm = 1'b0;
      s.op.imm     = addr;
      prog.push_back(s);
   endfunction

   function automatic word_t model_result(input uop_t u, input word_t a, input word_t b);
      case (u.alu_op)
         OP_ADD:     return a + b;
         OP_SUB:     return a - b;
         OP_AND:     return a & b;
         OP_OR:      return a | b;
         OP_XOR:     return a ^ b;
         OP_MOV_IMM: return u.imm;
         default:    return '0;
      endcase
   endfunction

   task automatic update_model(input step_t s);
      word_t   b;
      mem_wr_t e;
      b = s.op.use_imm ? s.op.imm : model_regs[s.op.src_b];
      if (s.is_store) begin
         e.address = s.op.imm;
         e.data    = model_regs[s.op.src_a];
         exp_q.push_back(e);
      end else begin
         model_regs[s.op.dest] = model_result(s.op, model_regs[s.op.src_a], b);
      end
   endtask

   task automatic check_store(input mem_wr_t got, input mem_wr_t exp);
      if (got !== exp) begin
         store_errors++;
         $display("CHECK FAILED wmem_req: got address %h data %h, expected address %h data %h",
                  got.address, got.data, exp.address, exp.data);
      end
   endtask

   task automatic check_count(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic send_step(input step_t s);
      int waited;
      waited = 0;
      uop_valid <= 1'b1;
      uop       <= s.op;
      do begin
         @(posedge clk);
         waited++;
      end while (!uop_ready && waited < SEND_TIMEOUT);
      if (!uop_ready) begin
         timeouts++;
         $display("Timeout: uop_ready stayed low for %0d cycles", SEND_TIMEOUT);
      end else begin
         update_model(s);
      end
   endtask

   task automatic wait_reset();
      int waited;
      waited = 0;
      while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (arst_n !== 1'b1) begin
         timeouts++;
         $display("Timeout: reset was never released");
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (stores_seen < exp_q.size() && waited < DRAIN_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (stores_seen < exp_q.size()) begin
         timeouts++;
         $display("Timeout: only %0d of %0d stores reached the memory port",
                  stores_seen, exp_q.size());
      end
   endtask

   // Random wmem_ready, forced low for a window once hold_req is set
   always @(posedge clk) begin
      rng = xorshift32(rng);
      if (hold_req && hold_cycles < HOLD_CYCLES) begin
         wmem_ready  <= 1'b0;
         hold_cycles <= hold_cycles + 1;
      end else begin
         wmem_ready <= rng[4];
      end
   end

   // Memory port monitor
   always @(posedge clk) begin
      if (wmem_valid && wmem_ready) begin
         if (stores_seen < exp_q.size()) begin
            check_store(wmem_req, exp_q[stores_seen]);
         end else begin
            store_errors++;
            $display("Memory write arrived with no store left to match it");
         end
         stores_seen <= stores_seen + 1;
      end
      if (waiting && (!wmem_valid || wmem_req !== held_req)) begin
         store_errors++;
         $display("Memory write request dropped or changed before wmem_ready");
      end
      waiting  <= wmem_valid && !wmem_ready;
      held_req <= wmem_req;
      if (hold_req && !uop_ready)
         saw_full <= 1'b1;
   end

   initial begin
      uop_valid = 1'b0;
      uop       = '0;
      for (int r = 0; r < NUM_REGS; r++)
         model_regs[r] = '0;

      // Registers read zero after reset
      for (int r = 0; r < NUM_REGS; r++)
         add_store_step(r, 32'h100 + 4 * r);
      add_alu_step(OP_MOV_IMM, 1, 0, 0, 1'b1, 32'h1234_5678);
      add_store_step(1, 32'h180);
      add_alu_step(OP_MOV_IMM, 2, 0, 0, 1'b1, 32'h0F0F_00FF);
      add_store_step(2, 32'h184);
      for (int k = 0; k < 5; k++) begin
         for (int m = 0; m < 2; m++) begin
            add_alu_step(alu_op_e'(k), 3, 1, 2, m == 1, 32'h00F0_0F0F + k);
            add_store_step(3, 32'h200 + 8 * k + 4 * m);
         end
      end
      // RAW chain, then WAW on r7
      add_alu_step(OP_ADD, 4, 1, 2, 1'b0, '0);
      add_alu_step(OP_ADD, 5, 4, 4, 1'b0, '0);
      add_alu_step(OP_SUB, 6, 5, 1, 1'b0, '0);
      add_alu_step(OP_XOR, 6, 6, 0, 1'b1, 32'hFFFF_0000);
      add_store_step(6, 32'h300);
      add_alu_step(OP_MOV_IMM, 7, 0, 0, 1'b1, 32'hAAAA_5555);
      add_alu_step(OP_MOV_IMM, 7, 0, 0, 1'b1, 32'h1357_9BDF);
      add_alu_step(OP_ADD, 7, 7, 0, 1'b1, 32'h1);
      add_store_step(7, 32'h304);
      hold_step = prog.size();
      for (int i = 0; i < 10; i++)
         add_store_step(i % 8, 32'h400 + 4 * i);

      wait_reset();
      for (int i = 0; i < prog.size() && timeouts == 0; i++) begin
         if (i == hold_step)
            hold_req <= 1'b1;
         send_step(prog[i]);
      end
      uop_valid <= 1'b0;
      if (timeouts == 0) begin
         wait_drain();
         repeat (SETTLE_CYCLES) @(posedge clk);   // Window for stray writes
      end
      if (timeouts == 0 && !saw_full) begin
         errors++;
         $display("uop_ready never fell while wmem_ready was held low");
      end
      check_count("stores_seen", word_t'(stores_seen), word_t'(exp_q.size()));

      $display("Errors: %0d check, %0d store, %0d timeout; %0d stores seen",
               errors, store_errors, timeouts, stores_seen);
      if (errors == 0 && store_errors == 0 && timeouts == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* uop_queue.sv */
`timescale 1ns/1ps

module uop_queue import stage_pkg::*; #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic clk,
   input  logic arst_n,
   input  logic uop_valid,
   output logic uop_ready,
   input  uop_t uop,
   output logic q_valid,
   input  logic q_ready,
   output uop_t q_uop
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);

   uop_t             mem [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             push;
   logic             pop;

   assign uop_ready = (count != (PTR_W + 1)'(QUEUE_DEPTH));
   assign q_valid   = (count != '0);
   assign q_uop     = mem[rd_ptr];

   assign push = uop_valid & uop_ready;
   assign pop  = q_valid & q_ready;

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= uop;
   end

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* writeback.sv */
`timescale 1ns/1ps

module writeback import stage_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    ex_valid,
   output logic    ex_ready,
   input  wb_in_t  ex_out,
   output reg_wr_t reg_wr,
   output logic    wmem_valid,
   input  logic    wmem_ready,
   output mem_wr_t wmem_req
);

   logic store_take;
   logic slot_free;

   // Request register empties or drains this cycle
   assign slot_free = ~wmem_valid | wmem_ready;

   // Register ops always retire, stores wait for the slot
   assign ex_ready   = ~ex_out.is_store | slot_free;
   assign store_take = ex_valid & ex_out.is_store & slot_free;

   assign reg_wr.en   = ex_valid & ~ex_out.is_store;
   assign reg_wr.idx  = ex_out.dest;
   assign reg_wr.data = ex_out.result;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         wmem_valid <= 1'b0;
      else if (store_take)
         wmem_valid <= 1'b1;
      else if (wmem_ready)
         wmem_valid <= 1'b0;
   end

   // Held stable until wmem_ready
   always_ff @(posedge clk) begin
      if (store_take) begin
         wmem_req.address <= ex_out.store_addr;
         wmem_req.data    <= ex_out.result;
      end
   end

endmodule
